/* rtl/conv_cfg_pkg.sv */
package conv_cfg_pkg;

    //////////////////////////////////////////////////
    // convolution geometry
    //////////////////////////////////////////////////

    localparam int DIM_W    = 16;
    localparam int KPARAM_W = 4;

    // row counts, row indices and buffer addresses
    typedef logic [DIM_W-1:0] dim_t;

    // kernel size, stride and pad
    typedef logic [KPARAM_W-1:0] kparam_t;

    //////////////////////////////////////////////////
    // limits and sentinels
    //////////////////////////////////////////////////

    // padding row or lane past the last output row
    localparam dim_t ROW_NONE = '1;

    // output rows per tile, one lane for each
    localparam int LANES = 3;

    // stride 1 and stride 2 only
    localparam kparam_t STRIDE_MAX = 4'd2;

endpackage

/* rtl/conv_buf_pkg.sv */
package conv_buf_pkg;

    //////////////////////////////////////////////////
    // line buffer organisation
    //////////////////////////////////////////////////

    // input rows rotate over three banks
    localparam int BUF_BANKS = 3;
    localparam int BANK_W    = 2;
    localparam int SLOT_W    = 16;

    typedef logic [BANK_W-1:0] bank_t;

    //////////////////////////////////////////////////
    // buffer position of one input row
    //////////////////////////////////////////////////

    // stride 1: bank = row mod 3, slot = row div 3
    // stride 2: rows pair up, bank = (row div 2) mod 3, pair_slot = row div 6.
    // pair_slot and phase sit where the stride 1 slot sits, so the upper
    // bits read back as slot = 2 * pair_slot + phase
    typedef union packed {
        struct packed {
            logic [SLOT_W-1:0] slot;
            bank_t             bank;
        } s1;
        struct packed {
            logic [SLOT_W-2:0] pair_slot;
            logic              phase;
            bank_t             bank;
        } s2;
    } buf_pos_u;

endpackage

/* rtl/conv_tile_if.sv */
`timescale 1ns/10ps

interface conv_tile_if
    import conv_cfg_pkg::*;
();

    // one kernel row step of the current tile
    logic       step;
    // first output row of the tile, 3m
    dim_t       oy_start;
    // valid output rows in the tile, 1 to 3
    logic [1:0] poy;
    kparam_t    idx_in_k;
    // tile number m
    dim_t       base_m;
    // final step of the job
    logic       last;

    modport walker (output step, oy_start, poy, idx_in_k, base_m, last);

    // no handshake, lanes take every step
    modport lane (input step, oy_start, poy, idx_in_k, base_m);

endinterface

/* rtl/conv_tile_walker.sv */
`timescale 1ns/10ps

module conv_tile_walker
    import conv_cfg_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        req,
    input  dim_t        oy,
    input  kparam_t     k,
    output logic        ack,
    conv_tile_if.walker tile
);

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_RUN   = 2'd1;
    localparam logic [1:0] ST_DRAIN = 2'd2;
    localparam logic [1:0] ST_DONE  = 2'd3;

    logic [1:0] state;
    logic       step_q;
    kparam_t    idx_q;
    dim_t       m_q;
    dim_t       start_q;
    logic [1:0] poy_q;
    logic       drain_q;
    logic       tile_end;
    logic       final_step;
    dim_t       next_start;
    dim_t       rows_left;

    // rows in a tile, capped at the lane count
    function automatic logic [1:0] tile_rows(input dim_t left);
        if (left >= dim_t'(LANES)) begin
            return 2'(LANES);
        end
        return left[1:0];
    endfunction

    //////////////////////////////////////////////////
    // step sequence
    //////////////////////////////////////////////////

    assign tile_end   = step_q && (idx_q == k - 4'd1);
    assign next_start = start_q + dim_t'(LANES);
    assign final_step = tile_end && (next_start >= oy);
    // only read when another tile follows
    assign rows_left  = oy - next_start;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= ST_IDLE;
            step_q  <= 1'b0;
            idx_q   <= '0;
            m_q     <= '0;
            start_q <= '0;
            poy_q   <= '0;
            drain_q <= 1'b0;
            ack     <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req) begin
                        state   <= ST_RUN;
                        step_q  <= 1'b1;
                        idx_q   <= '0;
                        m_q     <= '0;
                        start_q <= '0;
                        poy_q   <= tile_rows(oy);
                    end
                end
                ST_RUN: begin
                    if (final_step) begin
                        state   <= ST_DRAIN;
                        step_q  <= 1'b0;
                        drain_q <= 1'b0;
                    end else if (tile_end) begin
                        // next tile, kernel row back to 0
                        idx_q   <= '0;
                        m_q     <= m_q + 16'd1;
                        start_q <= next_start;
                        poy_q   <= tile_rows(rows_left);
                    end else begin
                        idx_q <= idx_q + 4'd1;
                    end
                end
                ST_DRAIN: begin
                    // two lane stages still in flight
                    drain_q <= 1'b1;
                    if (drain_q) begin
                        state <= ST_DONE;
                        ack   <= 1'b1;
                    end
                end
                ST_DONE: begin
                    if (!req) begin
                        state <= ST_IDLE;
                        ack   <= 1'b0;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    assign tile.step     = step_q;
    assign tile.oy_start = start_q;
    assign tile.poy      = poy_q;
    assign tile.idx_in_k = idx_q;
    assign tile.base_m   = m_q;
    assign tile.last     = final_step;

endmodule

/* rtl/conv_row_lane.sv */
`timescale 1ns/10ps

module conv_row_lane
    import conv_cfg_pkg::*;
    import conv_buf_pkg::*;
#(
    parameter int lane_id            = 0,
    parameter int pixels_in_row_log2 = 5
) (
    input  logic      clk,
    input  logic      arst_n,
    input  kparam_t   s,
    input  kparam_t   p,
    input  dim_t      iy,
    input  kparam_t   nif_log2,
    input  kparam_t   ix_log2,
    conv_tile_if.lane tile,
    output logic      step_valid,
    output dim_t      row_idx,
    output logic      row_valid,
    output bank_t     bank,
    output dim_t      adr
);

    // stage 1
    logic [7:0]         lane_off;
    logic signed [7:0]  s3;
    logic signed [7:0]  bias0;
    logic [1:0]         n_borrow;
    logic signed [7:0]  borrow_rows;
    logic signed [7:0]  bias;
    dim_t               base0;
    logic signed [17:0] base;
    logic signed [17:0] row;
    dim_t               m_eff;
    logic               row_ok;
    logic               row_hit;

    logic               st1_step;
    logic               st1_ok;
    dim_t               st1_row;
    logic [7:0]         st1_bias;
    dim_t               st1_m;

    // stage 2
    logic               leq3;
    logic               leq6;
    logic               leq9;
    logic [1:0]         grp;
    logic [7:0]         rem;
    logic [7:0]         pair_rem;
    logic [2:0]         pair_pos;
    logic               wrap1;
    logic               wrap2;
    buf_pos_u           pos;
    logic [5:0]         shamt;

    //////////////////////////////////////////////////
    // stage 1: base and bias
    //////////////////////////////////////////////////

    assign lane_off = 8'(lane_id) * {4'b0, s};
    assign s3       = $signed({4'b0, s} + {3'b0, s, 1'b0});
    assign bias0    = $signed(lane_off + {4'b0, tile.idx_in_k} - {4'b0, p});

    // non-positive bias borrows whole periods of 3s rows from the base
    always_comb begin
        if (bias0 > 8'sd0) begin
            n_borrow = 2'd0;
        end else if (bias0 > -s3) begin
            n_borrow = 2'd1;
        end else if (bias0 > -(s3 <<< 1)) begin
            n_borrow = 2'd2;
        end else begin
            n_borrow = 2'd3;
        end
    end

    assign borrow_rows = (n_borrow[1] ? (s3 <<< 1) : 8'sd0) + (n_borrow[0] ? s3 : 8'sd0);
    assign bias        = bias0 + borrow_rows;

    // 3*s*m, oy_start already holds 3m
    assign base0 = (s == STRIDE_MAX) ? (tile.oy_start << 1) : tile.oy_start;
    assign base  = $signed({2'b00, base0}) - borrow_rows;
    assign row   = base + bias;
    assign m_eff = tile.base_m - {14'b0, n_borrow};

    assign row_ok  = (tile.poy > 2'(lane_id)) && (row >= 18'sd0)
                     && (row < $signed({2'b00, iy}));
    assign row_hit = tile.step && row_ok;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            st1_step <= 1'b0;
            st1_ok   <= 1'b0;
        end else begin
            st1_step <= tile.step;
            st1_ok   <= row_hit;
        end
    end

    always_ff @(posedge clk) begin
        st1_row  <= row_hit ? row[15:0] : ROW_NONE;
        st1_bias <= $unsigned(bias);
        st1_m    <= m_eff;
    end

    //////////////////////////////////////////////////
    // stage 2: bias decode into the line buffer
    //////////////////////////////////////////////////

    // bias window 1..12 covers kernels up to 7 rows
    assign leq3 = st1_bias <= 8'd3;
    assign leq6 = st1_bias <= 8'd6;
    assign leq9 = st1_bias <= 8'd9;
    assign grp  = leq6 ? (leq3 ? 2'd0 : 2'd1) : (leq9 ? 2'd2 : 2'd3);

    // remainder 1..3 within a group of three rows
    assign rem   = st1_bias - {6'b0, grp} - {5'b0, grp, 1'b0};
    assign wrap1 = rem == 8'(BUF_BANKS);

    // stride 2 works in groups of six rows
    assign pair_rem = rem + (grp[0] ? 8'd3 : 8'd0);
    assign wrap2    = pair_rem == 8'(2 * BUF_BANKS);
    assign pair_pos = wrap2 ? 3'd0 : pair_rem[2:0];

    always_comb begin
        pos = '0;
        if (s == STRIDE_MAX) begin
            pos.s2.pair_slot = 15'(st1_m + {15'b0, grp[1]} + {15'b0, wrap2});
            pos.s2.phase     = pair_pos[0];
            pos.s2.bank      = pair_pos[2:1];
        end else begin
            pos.s1.slot = st1_m + {14'b0, grp} + {15'b0, wrap1};
            pos.s1.bank = wrap1 ? 2'd0 : rem[1:0];
        end
    end

    // words per buffer row
    assign shamt = {2'b0, nif_log2} + {2'b0, ix_log2} - 6'(pixels_in_row_log2);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            step_valid <= 1'b0;
            row_valid  <= 1'b0;
        end else begin
            step_valid <= st1_step;
            row_valid  <= st1_ok;
        end
    end

    // slot and bank read through the stride 1 view in both modes
    always_ff @(posedge clk) begin
        row_idx <= st1_row;
        bank    <= st1_ok ? pos.s1.bank : '0;
        adr     <= st1_ok ? (pos.s1.slot << shamt) : ROW_NONE;
    end

endmodule

/* rtl/conv_router.sv */
`timescale 1ns/10ps

module conv_router
    import conv_cfg_pkg::*;
    import conv_buf_pkg::*;
#(
    parameter int pixels_in_row_log2 = 5
) (
    input  logic    clk,
    input  logic    arst_n,
    input  logic    req,
    input  dim_t    oy,
    input  dim_t    iy,
    input  kparam_t k,
    input  kparam_t s,
    input  kparam_t p,
    input  kparam_t nif_log2,
    input  kparam_t ix_log2,
    output logic    ack,
    output logic    step_valid,
    output dim_t    row1_idx,
    output dim_t    row2_idx,
    output dim_t    row3_idx,
    output logic    row1_valid,
    output logic    row2_valid,
    output logic    row3_valid,
    output bank_t   row1_bank,
    output bank_t   row2_bank,
    output bank_t   row3_bank,
    output dim_t    row1_adr,
    output dim_t    row2_adr,
    output dim_t    row3_adr
);

    conv_tile_if tile_bus ();

    //////////////////////////////////////////////////
    // job control and tile steps
    //////////////////////////////////////////////////

    conv_tile_walker walker0 (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (req),
        .oy     (oy),
        .k      (k),
        .ack    (ack),
        .tile   (tile_bus.walker)
    );

    //////////////////////////////////////////////////
    // one lane per output row of the tile
    //////////////////////////////////////////////////

    conv_row_lane #(
        .lane_id            (0),
        .pixels_in_row_log2 (pixels_in_row_log2)
    ) lane0 (
        .clk        (clk),
        .arst_n     (arst_n),
        .s          (s),
        .p          (p),
        .iy         (iy),
        .nif_log2   (nif_log2),
        .ix_log2    (ix_log2),
        .tile       (tile_bus.lane),
        .step_valid (step_valid),
        .row_idx    (row1_idx),
        .row_valid  (row1_valid),
        .bank       (row1_bank),
        .adr        (row1_adr)
    );

    // step timing comes from lane0 only
    conv_row_lane #(
        .lane_id            (1),
        .pixels_in_row_log2 (pixels_in_row_log2)
    ) lane1 (
        .clk        (clk),
        .arst_n     (arst_n),
        .s          (s),
        .p          (p),
        .iy         (iy),
        .nif_log2   (nif_log2),
        .ix_log2    (ix_log2),
        .tile       (tile_bus.lane),
        .step_valid (),
        .row_idx    (row2_idx),
        .row_valid  (row2_valid),
        .bank       (row2_bank),
        .adr        (row2_adr)
    );

    conv_row_lane #(
        .lane_id            (2),
        .pixels_in_row_log2 (pixels_in_row_log2)
    ) lane2 (
        .clk        (clk),
        .arst_n     (arst_n),
        .s          (s),
        .p          (p),
        .iy         (iy),
        .nif_log2   (nif_log2),
        .ix_log2    (ix_log2),
        .tile       (tile_bus.lane),
        .step_valid (),
        .row_idx    (row3_idx),
        .row_valid  (row3_valid),
        .bank       (row3_bank),
        .adr        (row3_adr)
    );

endmodule

/* verif/conv_router_assert.sv */
`timescale 1ns/10ps

module conv_router_assert
    import conv_cfg_pkg::*;
(
    input logic    clk,
    input logic    arst_n,
    input logic    req,
    input logic    ack,
    input logic    step_valid,
    input kparam_t s,
    input dim_t    iy,
    input dim_t    row1_idx,
    input dim_t    row2_idx,
    input dim_t    row3_idx,
    input logic    row1_valid,
    input logic    row2_valid,
    input logic    row3_valid,
    input dim_t    row1_adr
);

    ////////////////////////////////////////////////////
    // handshake
    ////////////////////////////////////////////////////

    a_step_in_job: assert property (@(posedge clk) disable iff (!arst_n)
        step_valid |-> req) else $error("step_valid outside a job");

    a_ack_after_steps: assert property (@(posedge clk) disable iff (!arst_n)
        ack |-> !step_valid) else $error("step_valid together with ack");

    a_ack_falls_late: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(ack) |-> !$past(req)) else $error("ack fell before req");

    ////////////////////////////////////////////////////
    // rows, each lane one stride above the previous
    ////////////////////////////////////////////////////

    a_lane2_row: assert property (@(posedge clk) disable iff (!arst_n)
        (step_valid && row1_valid && row2_valid) |-> (row2_idx == row1_idx + dim_t'(s)))
        else $error("lane 2 row is not lane 1 row plus stride");

    a_lane3_row: assert property (@(posedge clk) disable iff (!arst_n)
        (step_valid && row2_valid && row3_valid) |-> (row3_idx == row2_idx + dim_t'(s)))
        else $error("lane 3 row is not lane 2 row plus stride");

    a_row_in_map: assert property (@(posedge clk) disable iff (!arst_n)
        (step_valid && row1_valid) |-> (row1_idx < iy)) else $error("lane 1 row past iy");

    a_pad_marked: assert property (@(posedge clk) disable iff (!arst_n)
        (step_valid && !row1_valid) |-> (row1_idx == ROW_NONE && row1_adr == ROW_NONE))
        else $error("lane 1 padding row not marked");

endmodule

bind conv_router conv_router_assert assert0 (
    .clk        (clk),
    .arst_n     (arst_n),
    .req        (req),
    .ack        (ack),
    .step_valid (step_valid),
    .s          (s),
    .iy         (iy),
    .row1_idx   (row1_idx),
    .row2_idx   (row2_idx),
    .row3_idx   (row3_idx),
    .row1_valid (row1_valid),
    .row2_valid (row2_valid),
    .row3_valid (row3_valid),
    .row1_adr   (row1_adr)
);

/* verif/conv_router_tb.sv */
`timescale 1ns/10ps

module conv_router_tb
    import conv_cfg_pkg::*;
    import conv_buf_pkg::*;
();

    localparam int NUM_CASES    = 8;
    localparam int RESET_CYCLES = 16;
    localparam int PIX_LOG2     = 5;

    // one job and its step count ceil(oy/3) * k
    typedef struct packed {
        int oy;
        int iy;
        int k;
        int s;
        int p;
        int nif_log2;
        int ix_log2;
        int steps;
    } case_t;

    logic    clk;
    logic    arst_n;
    logic    req;
    dim_t    oy;
    dim_t    iy;
    kparam_t k;
    kparam_t s;
    kparam_t p;
    kparam_t nif_log2;
    kparam_t ix_log2;
    logic    ack;
    logic    step_valid;
    dim_t    row_idx   [LANES];
    logic    row_valid [LANES];
    bank_t   row_bank  [LANES];
    dim_t    row_adr   [LANES];

    case_t cases [NUM_CASES];
    int    checks;
    int    errors;
    int    case_errors;
    int    cycles;
    int    limit;

    conv_router #(
        .pixels_in_row_log2 (PIX_LOG2)
    ) dut0 (
        .clk        (clk),
        .arst_n     (arst_n),
        .req        (req),
        .oy         (oy),
        .iy         (iy),
        .k          (k),
        .s          (s),
        .p          (p),
        .nif_log2   (nif_log2),
        .ix_log2    (ix_log2),
        .ack        (ack),
        .step_valid (step_valid),
        .row1_idx   (row_idx[0]),
        .row2_idx   (row_idx[1]),
        .row3_idx   (row_idx[2]),
        .row1_valid (row_valid[0]),
        .row2_valid (row_valid[1]),
        .row3_valid (row_valid[2]),
        .row1_bank  (row_bank[0]),
        .row2_bank  (row_bank[1]),
        .row3_bank  (row_bank[2]),
        .row1_adr   (row_adr[0]),
        .row2_adr   (row_adr[1]),
        .row3_adr   (row_adr[2])
    );

    always #2 clk = ~clk;

    //////////////////////////////////////////////////
    // case table and reference model
    //////////////////////////////////////////////////

    task automatic load_cases();
        // oy, iy, k, s, p, nif_log2, ix_log2, steps
        cases[0] = '{6, 6, 3, 1, 1, 3, 3, 6};
        cases[1] = '{7, 9, 5, 1, 2, 2, 4, 15};
        cases[2] = '{4, 10, 7, 1, 6, 3, 2, 14};
        cases[3] = '{5, 11, 3, 2, 1, 3, 4, 6};
        cases[4] = '{4, 9, 4, 2, 0, 2, 3, 8};
        cases[5] = '{9, 20, 7, 2, 3, 5, 5, 21};
        cases[6] = '{10, 10, 1, 1, 0, 1, 4, 4};
        cases[7] = '{11, 23, 5, 2, 4, 4, 4, 20};
    endtask

    // expected lane outputs for step n of case c
    function automatic void expect_lane(input int c, input int n, input int l,
                                        output int e_idx, output int e_valid,
                                        output int e_bank, output int e_adr);
        int m;
        int j;
        int poy;
        int r;
        int slot;
        m   = n / cases[c].k;
        j   = n % cases[c].k;
        poy = cases[c].oy - 3 * m;
        if (poy > LANES) begin
            poy = LANES;
        end
        r = 3 * cases[c].s * m + l * cases[c].s + j - cases[c].p;
        if (l < poy && r >= 0 && r < cases[c].iy) begin
            if (cases[c].s == 1) begin
                e_bank = r % 3;
                slot   = r / 3;
            end else begin
                // pairs of rows share a bank
                e_bank = (r / 2) % 3;
                slot   = 2 * (r / 6) + r % 2;
            end
            e_idx   = r;
            e_valid = 1;
            e_adr   = (slot << (cases[c].nif_log2 + cases[c].ix_log2 - PIX_LOG2)) & 'hffff;
        end else begin
            e_idx   = int'(ROW_NONE);
            e_valid = 0;
            e_bank  = 0;
            e_adr   = int'(ROW_NONE);
        end
    endfunction

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    task automatic compare_value(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
        checks++;
        if (act_v !== exp_v) begin
            errors++;
            case_errors++;
            $display("ERROR %s: expected 0x%0h, got 0x%0h", name, exp_v, act_v);
        end
    endtask

    task automatic report_failure(input string msg);
        errors++;
        case_errors++;
        $display("%s", msg);
    endtask

    task automatic check_step(input int c, input int n);
        int l;
        int e_idx;
        int e_valid;
        int e_bank;
        int e_adr;
        for (l = 0; l < LANES; l++) begin
            expect_lane(c, n, l, e_idx, e_valid, e_bank, e_adr);
            compare_value($sformatf("row%0d_idx step %0d", l + 1, n), 32'(e_idx),
                          32'(row_idx[l]));
            compare_value($sformatf("row%0d_valid step %0d", l + 1, n), 32'(e_valid),
                          32'(row_valid[l]));
            compare_value($sformatf("row%0d_bank step %0d", l + 1, n), 32'(e_bank),
                          32'(row_bank[l]));
            compare_value($sformatf("row%0d_adr step %0d", l + 1, n), 32'(e_adr),
                          32'(row_adr[l]));
        end
    endtask

    task automatic run_case(input int c);
        int n_steps;
        int hold;
        int waits;
        int lat;
        bit done;
        bit prev_sv;
        case_errors = 0;
        n_steps     = 0;
        lat         = 0;
        done        = 1'b0;
        prev_sv     = 1'b0;
        hold        = int'($urandom_range(3, 0));
        @(posedge clk);
        oy       <= dim_t'(cases[c].oy);
        iy       <= dim_t'(cases[c].iy);
        k        <= kparam_t'(cases[c].k);
        s        <= kparam_t'(cases[c].s);
        p        <= kparam_t'(cases[c].p);
        nif_log2 <= kparam_t'(cases[c].nif_log2);
        ix_log2  <= kparam_t'(cases[c].ix_log2);
        req      <= 1'b1;
        // collect every step until the job is acknowledged
        while (!done) begin
            @(negedge clk);
            lat++;
            if (step_valid) begin
                if (n_steps == 0) begin
                    // clock edges from req to the first step
                    compare_value($sformatf("step_valid latency case %0d", c), 32'd3,
                                  32'(lat - 1));
                end else if (!prev_sv) begin
                    report_failure($sformatf("case %0d: gap in the step_valid run", c));
                end
                if (n_steps < cases[c].steps) begin
                    check_step(c, n_steps);
                end
                n_steps++;
            end
            if (ack) begin
                done = 1'b1;
                if (!prev_sv) begin
                    report_failure($sformatf("case %0d: ack rose without a step just before", c));
                end
            end
            prev_sv = step_valid;
        end
        compare_value($sformatf("step_valid count case %0d", c), 32'(cases[c].steps),
                      32'(n_steps));
        // ack must hold while the host keeps req up
        repeat (hold) begin
            @(negedge clk);
            if (!ack) begin
                report_failure($sformatf("case %0d: ack fell while req was still high", c));
            end
            if (step_valid) begin
                report_failure($sformatf("case %0d: step_valid after ack", c));
            end
        end
        @(posedge clk);
        req   <= 1'b0;
        waits = 0;
        do begin
            @(negedge clk);
            waits++;
            if (step_valid) begin
                report_failure($sformatf("case %0d: step_valid while req was low", c));
            end
        end while (ack && waits < 4);
        if (ack) begin
            report_failure($sformatf("case %0d: ack did not fall after req dropped", c));
        end
        $display("case %0d: oy=%0d iy=%0d k=%0d s=%0d p=%0d, %0d steps, %0d errors", c,
                 cases[c].oy, cases[c].iy, cases[c].k, cases[c].s, cases[c].p, n_steps,
                 case_errors);
    endtask

    //////////////////////////////////////////////////
    // watchdog
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout: run went past %0d cycles", limit);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin
        clk      = 1'b0;
        arst_n   = 1'b0;
        req      = 1'b0;
        oy       = '0;
        iy       = '0;
        k        = '0;
        s        = '0;
        p        = '0;
        nif_log2 = '0;
        ix_log2  = '0;
        checks   = 0;
        errors   = 0;
        cycles   = 0;
        void'($urandom(67905));
        load_cases();
        limit = RESET_CYCLES;
        for (int c = 0; c < NUM_CASES; c++) begin
            limit += cases[c].steps + 20;
        end
        repeat (RESET_CYCLES - 1) @(posedge clk);
        // outputs quiet while in reset
        @(negedge clk);
        compare_value("ack in reset", 32'd0, 32'(ack));
        compare_value("step_valid in reset", 32'd0, 32'(step_valid));
        for (int l = 0; l < LANES; l++) begin
            compare_value($sformatf("row%0d_valid in reset", l + 1), 32'd0, 32'(row_valid[l]));
        end
        @(posedge clk);
        arst_n <= 1'b1;
        for (int c = 0; c < NUM_CASES; c++) begin
            run_case(c);
        end
        $display("cases %0d, checks %0d, errors %0d", NUM_CASES, checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* conv_router.f */
rtl/conv_cfg_pkg.sv
rtl/conv_buf_pkg.sv
rtl/conv_tile_if.sv
rtl/conv_tile_walker.sv
rtl/conv_row_lane.sv
rtl/conv_router.sv
verif/conv_router_assert.sv
verif/conv_router_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the conv_router testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module conv_router_tb \
    -f conv_router.f \
    -o conv_router_sim

./obj_dir/conv_router_sim 2>&1 | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    exit 1
fi
